// ==== rv32i_defs.svh ====
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

`define RV_XLEN         32
`define RV_RADDR_W      5
`define RV_NREGS        32

// Debug slave address map
`define RV_DBG_CTRL     32'h0000_0000 // Bit 0 holds the halt request
`define RV_DBG_REG_BASE 32'h0000_0080 // Register n sits at base plus 4n

`endif

// ==== logic/rv32i_pkg.sv ====
`include "rv32i_defs.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0]    word_t;
    typedef logic [`RV_RADDR_W-1:0] reg_addr_t;

    // Read channel of the debug slave
    typedef enum logic [1:0] {
        dbg_rd_idle,
        dbg_rd_data,
        dbg_rd_resp
    } dbg_rd_state_t;

endpackage

// ==== logic/rv32i_reg.sv ====
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module rv32i_reg (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 flush,
    input  logic                 stall,
    input  logic                 mem_wait,

    input  rv32i_pkg::reg_addr_t a_raddr,
    output logic                 a_rvalid,
    output rv32i_pkg::reg_addr_t a_roaddr,
    output rv32i_pkg::word_t     a_rdata,

    input  rv32i_pkg::reg_addr_t b_raddr,
    output logic                 b_rvalid,
    output rv32i_pkg::reg_addr_t b_roaddr,
    output rv32i_pkg::word_t     b_rdata,

    input  rv32i_pkg::reg_addr_t pending_addr,
    input  logic                 exec_en,
    input  rv32i_pkg::reg_addr_t exec_addr,
    input  rv32i_pkg::word_t     exec_data,
    input  logic                 cush_en,
    input  rv32i_pkg::reg_addr_t cush_addr,
    input  rv32i_pkg::word_t     cush_data,

    input  rv32i_pkg::reg_addr_t waddr,
    input  rv32i_pkg::word_t     wdata,

    input  rv32i_pkg::reg_addr_t dbg_raddr,
    output rv32i_pkg::word_t     dbg_rdata
);
    import rv32i_pkg::*;

    reg_addr_t a_addr_q;
    reg_addr_t b_addr_q;
    reg_addr_t pend_q;
    logic      ex_en_q;
    reg_addr_t ex_addr_q;
    word_t     ex_data_q;
    logic      cu_en_q;
    reg_addr_t cu_addr_q;
    word_t     cu_data_q;

    word_t     regs [`RV_NREGS];

    always_ff @(posedge CLK) begin
        if (RST || flush) begin
            a_addr_q  <= '0;
            b_addr_q  <= '0;
            pend_q    <= '0;
            ex_en_q   <= 1'b0;
            ex_addr_q <= '0;
            cu_en_q   <= 1'b0;
            cu_addr_q <= '0;
        end else if (stall) begin
            pend_q    <= '0; // The stalled decode slot issues nothing
            ex_en_q   <= exec_en;
            ex_addr_q <= exec_addr;
            cu_en_q   <= cush_en;
            cu_addr_q <= cush_addr;
        end else if (!mem_wait) begin
            a_addr_q  <= a_raddr;
            b_addr_q  <= b_raddr;
            pend_q    <= pending_addr;
            ex_en_q   <= exec_en;
            ex_addr_q <= exec_addr;
            cu_en_q   <= cush_en;
            cu_addr_q <= cush_addr;
        end
    end

    always_ff @(posedge CLK) begin
        if (stall || !mem_wait) begin
            ex_data_q <= exec_data;
            cu_data_q <= cush_data;
        end
    end

    function automatic logic operand_valid(input reg_addr_t ra);
        logic ok;
        case (ra)
            '0:        ok = 1'b1;
            pend_q:    ok = 1'b0; // Load result still outstanding
            ex_addr_q: ok = ex_en_q;
            cu_addr_q: ok = cu_en_q;
            default:   ok = 1'b1;
        endcase
        return ok;
    endfunction

    function automatic word_t operand_data(input reg_addr_t ra);
        word_t d;
        case (ra)
            '0:        d = '0;
            ex_addr_q: d = ex_data_q;
            cu_addr_q: d = cu_data_q;
            waddr:     d = wdata;
            default:   d = regs[ra];
        endcase
        return d;
    endfunction

    always_comb begin
        a_roaddr = a_addr_q;
        a_rvalid = operand_valid(a_addr_q);
        a_rdata  = operand_data(a_addr_q);
        b_roaddr = b_addr_q;
        b_rvalid = operand_valid(b_addr_q);
        b_rdata  = operand_data(b_addr_q);
    end

    always_ff @(posedge CLK) begin
        if (waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Entry 0 is never written so it is forced to zero here
    assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

// ==== logic/rv32i_result_pipe.sv ====
`timescale 1ns/1ps

module rv32i_result_pipe (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 flush,
    input  logic                 mem_wait,

    input  logic                 exec_en,
    input  rv32i_pkg::reg_addr_t exec_addr,
    input  rv32i_pkg::word_t     exec_data,

    output logic                 cush_en,
    output rv32i_pkg::reg_addr_t cush_addr,
    output rv32i_pkg::word_t     cush_data,

    output rv32i_pkg::reg_addr_t waddr,
    output rv32i_pkg::word_t     wdata
);

    always_ff @(posedge CLK) begin
        if (RST || flush) begin
            cush_en   <= 1'b0;
            cush_addr <= '0;
            waddr     <= '0;
        end else if (!mem_wait) begin
            cush_en   <= exec_en;
            cush_addr <= exec_addr;
            waddr     <= cush_en ? cush_addr : '0; // Unknown results never retire
        end
    end

    always_ff @(posedge CLK) begin
        if (!mem_wait) begin
            cush_data <= exec_data;
            wdata     <= cush_data;
        end
    end

endmodule

// ==== logic/rv32i_dbg_axil.sv ====
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module rv32i_dbg_axil (
    input  logic                 CLK,
    input  logic                 RST,

    input  logic                 awvalid,
    input  rv32i_pkg::word_t     awaddr,
    output logic                 awready,
    input  logic                 wvalid,
    input  rv32i_pkg::word_t     wdata,
    input  logic [3:0]           wstrb,
    output logic                 wready,
    output logic                 bvalid,
    output logic [1:0]           bresp,
    input  logic                 bready,

    input  logic                 arvalid,
    input  rv32i_pkg::word_t     araddr,
    output logic                 arready,
    output logic                 rvalid,
    output rv32i_pkg::word_t     rdata,
    output logic [1:0]           rresp,
    input  logic                 rready,

    output logic                 halted,

    output rv32i_pkg::reg_addr_t dbg_raddr,
    input  rv32i_pkg::word_t     dbg_rdata
);
    import rv32i_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic          aw_got;
    logic          w_got;
    word_t         aw_addr_q;
    word_t         w_data_q;
    logic [3:0]    w_strb_q;
    word_t         wr_addr;
    word_t         wr_data;
    logic [3:0]    wr_strb;
    logic          wr_fire;

    dbg_rd_state_t rd_state;
    logic          rd_ctrl;
    word_t         rd_hold;
    word_t         rd_live;
    word_t         ar_off;
    logic          ar_in_win;

    // Either half of a write may arrive first, the write fires once both are in
    assign awready = ~bvalid & ~aw_got;
    assign wready  = ~bvalid & ~w_got;
    assign wr_addr = aw_got ? aw_addr_q : awaddr;
    assign wr_data = w_got ? w_data_q : wdata;
    assign wr_strb = w_got ? w_strb_q : wstrb;
    assign wr_fire = (aw_got | (awvalid & awready)) & (w_got | (wvalid & wready));

    always_ff @(posedge CLK) begin
        if (RST) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b0;
            bresp  <= RESP_OKAY;
            halted <= 1'b0;
        end else if (wr_fire) begin
            aw_got <= 1'b0;
            w_got  <= 1'b0;
            bvalid <= 1'b1;
            if (wr_addr == `RV_DBG_CTRL) begin
                bresp <= RESP_OKAY;
                if (wr_strb[0]) begin
                    halted <= wr_data[0];
                end
            end else begin
                bresp <= RESP_SLVERR;
            end
        end else begin
            if (awvalid && awready) aw_got <= 1'b1;
            if (wvalid && wready)   w_got  <= 1'b1;
            if (bvalid && bready)   bvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (awvalid && awready) aw_addr_q <= awaddr;
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    assign ar_off    = araddr - `RV_DBG_REG_BASE; // Wraps high below the window
    assign ar_in_win = (ar_off < word_t'(4 * `RV_NREGS)) && (ar_off[1:0] == 2'b00);

    assign arready = (rd_state == dbg_rd_idle);
    assign rvalid  = (rd_state != dbg_rd_idle);
    assign rd_live = rd_ctrl ? {{(`RV_XLEN-1){1'b0}}, halted} : dbg_rdata;
    assign rdata   = (rd_state == dbg_rd_resp) ? rd_hold : rd_live;

    always_ff @(posedge CLK) begin
        if (RST) begin
            rd_state <= dbg_rd_idle;
        end else begin
            case (rd_state)
                dbg_rd_idle: if (arvalid) rd_state <= dbg_rd_data;
                dbg_rd_data: rd_state <= rready ? dbg_rd_idle : dbg_rd_resp;
                dbg_rd_resp: if (rready) rd_state <= dbg_rd_idle;
                default:     rd_state <= dbg_rd_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (arready && arvalid) begin
            rd_ctrl   <= (araddr == `RV_DBG_CTRL);
            dbg_raddr <= ar_in_win ? ar_off[`RV_RADDR_W+1:2] : '0; // Entry 0 reads zero
            rresp     <= (ar_in_win || araddr == `RV_DBG_CTRL) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_state == dbg_rd_data) begin
            rd_hold <= rd_live; // Keeps rdata stable while the master stalls
        end
    end

endmodule

// ==== logic/rv32i_operand_unit.sv ====
`timescale 1ns/1ps

module rv32i_operand_unit (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 flush,
    input  logic                 stall,
    input  logic                 mem_wait,

    input  rv32i_pkg::reg_addr_t a_raddr,
    output logic                 a_rvalid,
    output rv32i_pkg::reg_addr_t a_roaddr,
    output rv32i_pkg::word_t     a_rdata,
    input  rv32i_pkg::reg_addr_t b_raddr,
    output logic                 b_rvalid,
    output rv32i_pkg::reg_addr_t b_roaddr,
    output rv32i_pkg::word_t     b_rdata,
    input  rv32i_pkg::reg_addr_t pending_addr,

    input  logic                 exec_en,
    input  rv32i_pkg::reg_addr_t exec_addr,
    input  rv32i_pkg::word_t     exec_data,

    input  logic                 awvalid,
    input  rv32i_pkg::word_t     awaddr,
    output logic                 awready,
    input  logic                 wvalid,
    input  rv32i_pkg::word_t     wdata,
    input  logic [3:0]           wstrb,
    output logic                 wready,
    output logic                 bvalid,
    output logic [1:0]           bresp,
    input  logic                 bready,
    input  logic                 arvalid,
    input  rv32i_pkg::word_t     araddr,
    output logic                 arready,
    output logic                 rvalid,
    output rv32i_pkg::word_t     rdata,
    output logic [1:0]           rresp,
    input  logic                 rready,

    output logic                 halted
);
    import rv32i_pkg::*;

    logic      cush_en;
    reg_addr_t cush_addr;
    word_t     cush_data;
    reg_addr_t wb_addr;
    word_t     wb_data;
    reg_addr_t dbg_raddr;
    word_t     dbg_rdata;

    rv32i_result_pipe i_rv32i_result_pipe (
        .CLK       (CLK),
        .RST       (RST),
        .flush     (flush),
        .mem_wait  (mem_wait),
        .exec_en   (exec_en),
        .exec_addr (exec_addr),
        .exec_data (exec_data),
        .cush_en   (cush_en),
        .cush_addr (cush_addr),
        .cush_data (cush_data),
        .waddr     (wb_addr),
        .wdata     (wb_data)
    );

    rv32i_reg i_rv32i_reg (
        .CLK          (CLK),
        .RST          (RST),
        .flush        (flush),
        .stall        (stall),
        .mem_wait     (mem_wait),
        .a_raddr      (a_raddr),
        .a_rvalid     (a_rvalid),
        .a_roaddr     (a_roaddr),
        .a_rdata      (a_rdata),
        .b_raddr      (b_raddr),
        .b_rvalid     (b_rvalid),
        .b_roaddr     (b_roaddr),
        .b_rdata      (b_rdata),
        .pending_addr (pending_addr),
        .exec_en      (exec_en),
        .exec_addr    (exec_addr),
        .exec_data    (exec_data),
        .cush_en      (cush_en),
        .cush_addr    (cush_addr),
        .cush_data    (cush_data),
        .waddr        (wb_addr),
        .wdata        (wb_data),
        .dbg_raddr    (dbg_raddr),
        .dbg_rdata    (dbg_rdata)
    );

    rv32i_dbg_axil i_rv32i_dbg_axil (
        .CLK       (CLK),
        .RST       (RST),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awready   (awready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .bready    (bready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rready    (rready),
        .halted    (halted),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata)
    );

endmodule

// ==== test/rv32i_operand_model.svh ====
`ifndef RV32I_OPERAND_MODEL_SVH
`define RV32I_OPERAND_MODEL_SVH

// Reference copy of the array, both stages and the captured read side
word_t     m_regs [`RV_NREGS];
logic      m_cush_en   = 1'b0;
reg_addr_t m_cush_addr = '0;
word_t     m_cush_data;
reg_addr_t m_waddr     = '0;
word_t     m_wdata;
reg_addr_t m_a_addr    = '0;
reg_addr_t m_b_addr    = '0;
reg_addr_t m_pend      = '0;
logic      m_ex_en     = 1'b0;
reg_addr_t m_ex_addr   = '0;
word_t     m_ex_data;
logic      m_cu_en     = 1'b0;
reg_addr_t m_cu_addr   = '0;
word_t     m_cu_data;

task automatic advance_model();
    if (m_waddr != '0) begin
        m_regs[m_waddr] = m_wdata; // Array takes the writeback pair as it stood before the edge
    end
    if (RST || flush) begin
        m_a_addr  = '0;
        m_b_addr  = '0;
        m_pend    = '0;
        m_ex_en   = 1'b0;
        m_ex_addr = '0;
        m_cu_en   = 1'b0;
        m_cu_addr = '0;
    end else if (stall) begin
        m_pend    = '0; // The pending load is dropped while read addresses stay
        m_ex_en   = exec_en;
        m_ex_addr = exec_addr;
        m_cu_en   = m_cush_en;
        m_cu_addr = m_cush_addr;
    end else if (!mem_wait) begin
        m_a_addr  = a_raddr;
        m_b_addr  = b_raddr;
        m_pend    = pending_addr;
        m_ex_en   = exec_en;
        m_ex_addr = exec_addr;
        m_cu_en   = m_cush_en;
        m_cu_addr = m_cush_addr;
    end
    if (stall || !mem_wait) begin
        m_ex_data = exec_data;
        m_cu_data = m_cush_data;
    end
    if (RST || flush) begin
        m_cush_en   = 1'b0;
        m_cush_addr = '0;
        m_waddr     = '0;
    end else if (!mem_wait) begin
        m_waddr     = m_cush_en ? m_cush_addr : '0; // Unknown results never retire
        m_cush_en   = exec_en;
        m_cush_addr = exec_addr;
    end
    if (!mem_wait) begin
        m_wdata     = m_cush_data;
        m_cush_data = exec_data;
    end
endtask

function automatic logic expected_valid(input reg_addr_t ra);
    if (ra == '0) return 1'b1;
    if (ra == m_pend) return 1'b0;
    if (ra == m_ex_addr) return m_ex_en;
    if (ra == m_cu_addr) return m_cu_en;
    return 1'b1;
endfunction

function automatic word_t expected_data(input reg_addr_t ra);
    if (ra == '0) return '0;
    if (ra == m_ex_addr) return m_ex_data;
    if (ra == m_cu_addr) return m_cu_data;
    if (ra == m_waddr) return m_wdata;
    return m_regs[ra];
endfunction

function automatic word_t array_value(input reg_addr_t ra);
    return (ra == '0) ? '0 : m_regs[ra];
endfunction

`endif

// ==== test/rv32i_operand_unit_tb.sv ====
`timescale 1ns/1ps
`include "rv32i_defs.svh"

module rv32i_operand_unit_tb;
    import rv32i_pkg::*;

    localparam int         TIMEOUT = 20;
    localparam logic [1:0] OKAY    = 2'b00;
    localparam logic [1:0] SLVERR  = 2'b10;

    logic      CLK;
    logic      RST;
    logic      flush;
    logic      stall;
    logic      mem_wait;
    reg_addr_t a_raddr;
    logic      a_rvalid;
    reg_addr_t a_roaddr;
    word_t     a_rdata;
    reg_addr_t b_raddr;
    logic      b_rvalid;
    reg_addr_t b_roaddr;
    word_t     b_rdata;
    reg_addr_t pending_addr;
    logic      exec_en;
    reg_addr_t exec_addr;
    word_t     exec_data;
    logic      awvalid;
    word_t     awaddr;
    logic      awready;
    logic      wvalid;
    word_t     wdata;
    logic [3:0] wstrb;
    logic      wready;
    logic      bvalid;
    logic [1:0] bresp;
    logic      bready;
    logic      arvalid;
    word_t     araddr;
    logic      arready;
    logic      rvalid;
    word_t     rdata;
    logic [1:0] rresp;
    logic      rready;
    logic      halted;

    word_t     rng = 32'd66;

    `include "rv32i_operand_model.svh"

    rv32i_operand_unit i_rv32i_operand_unit (.*);

    always #5 CLK = ~CLK;

    always @(posedge CLK) advance_model();

    function automatic word_t xorshift32(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function word_t rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic word_t fill_word(input reg_addr_t n);
        return (32'(n) * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
    endfunction

    task compare(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task report_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
        $display("TEST FAILED");
        $fatal(1, "Handshake timeout");
    endtask

    task verify_ports(input string name);
        compare({name, " a_roaddr"}, 32'(m_a_addr), 32'(a_roaddr));
        compare({name, " a_rvalid"}, 32'(expected_valid(m_a_addr)), 32'(a_rvalid));
        compare({name, " a_rdata"}, expected_data(m_a_addr), a_rdata);
        compare({name, " b_roaddr"}, 32'(m_b_addr), 32'(b_roaddr));
        compare({name, " b_rvalid"}, 32'(expected_valid(m_b_addr)), 32'(b_rvalid));
        compare({name, " b_rdata"}, expected_data(m_b_addr), b_rdata);
    endtask

    task next_cycle(input string name);
        @(negedge CLK);
        verify_ports(name);
    endtask

    // Steers a read address onto one of the forwarding sources most of the time
    function automatic reg_addr_t pick_addr(input word_t r);
        reg_addr_t ra;
        case (r[7:5])
            3'd0:    ra = exec_addr;
            3'd1:    ra = m_cush_addr;
            3'd2:    ra = m_waddr;
            3'd3:    ra = pending_addr;
            3'd4:    ra = m_cu_addr;
            default: ra = r[4:0];
        endcase
        return ra;
    endfunction

    task idle_inputs();
        exec_en      = 1'b1;
        exec_addr    = '0;
        exec_data    = '0;
        pending_addr = '0;
        stall        = 1'b0;
        mem_wait     = 1'b0;
        flush        = 1'b0;
    endtask

    task random_inputs(input logic bias, input logic ctrl);
        word_t r;
        word_t s;
        r            = rand32();
        s            = rand32();
        exec_data    = rand32();
        exec_addr    = r[4:0];
        exec_en      = (r[7:5] != 3'd0);
        pending_addr = (r[9:8] == 2'd0) ? r[14:10] : '0;
        a_raddr      = bias ? pick_addr(s) : s[4:0];
        b_raddr      = bias ? pick_addr(s >> 8) : s[12:8];
        stall        = ctrl && (r[18:16] == 3'd0);
        mem_wait     = ctrl && (r[21:19] == 3'd0);
        flush        = ctrl && (r[25:22] == 4'd0);
    endtask

    task write_debug(input string name, input word_t addr, input word_t data,
                     input logic [1:0] exp_resp);
        int cnt;
        @(negedge CLK);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        bready  = 1'b1;
        cnt = 0;
        while (!(awready && wready)) begin
            @(negedge CLK);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("write address and data acceptance");
        end
        @(negedge CLK); // Both halves were taken at the edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cnt = 0;
        while (!bvalid) begin
            @(negedge CLK);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("write response");
        end
        compare({name, " bresp"}, 32'(exp_resp), 32'(bresp));
        @(negedge CLK);
        bready = 1'b0;
    endtask

    task read_debug(input string name, input word_t addr, input word_t exp_data,
                    input logic [1:0] exp_resp, input logic chk_data);
        int            cnt;
        int            lat;
        int            hold;
        word_t         r;
        dbg_rd_state_t want;
        want = dbg_rd_data;
        @(negedge CLK);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b0;
        cnt = 0;
        while (!arready) begin
            @(negedge CLK);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("read address acceptance");
        end
        @(negedge CLK);
        arvalid = 1'b0;
        lat = 1;
        while (!rvalid) begin
            @(negedge CLK);
            lat++;
            if (lat > TIMEOUT) report_timeout($sformatf("read channel state %s", want.name()));
        end
        compare({name, " latency"}, 32'd1, 32'(lat));
        r    = rand32();
        hold = int'(r[1:0]);
        repeat (hold) begin
            compare({name, " rvalid held"}, 32'd1, 32'(rvalid));
            if (chk_data) compare({name, " rdata held"}, exp_data, rdata);
            @(negedge CLK);
        end
        rready = 1'b1;
        compare({name, " rvalid"}, 32'd1, 32'(rvalid));
        compare({name, " rresp"}, 32'(exp_resp), 32'(rresp));
        if (chk_data) compare({name, " rdata"}, exp_data, rdata);
        @(negedge CLK);
        rready = 1'b0;
        compare({name, " rvalid clear"}, 32'd0, 32'(rvalid));
    endtask

    initial begin
        word_t saved;
        word_t r;
        CLK     = 1'b0;
        RST     = 1'b1;
        a_raddr = '0;
        b_raddr = '0;
        idle_inputs();
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        compare("reset a_roaddr", 32'd0, 32'(a_roaddr));
        compare("reset a_rdata", 32'd0, a_rdata);
        compare("reset a_rvalid", 32'd1, 32'(a_rvalid));
        compare("reset b_roaddr", 32'd0, 32'(b_roaddr));
        compare("reset b_rdata", 32'd0, b_rdata);
        compare("reset b_rvalid", 32'd1, 32'(b_rvalid));
        compare("reset halted", 32'd0, 32'(halted));
        compare("reset ready", 32'b111, 32'({awready, wready, arready}));
        compare("reset resp valid", 32'd0, 32'({bvalid, rvalid}));

        // Give every register a known value before anything reads the array
        for (int n = 1; n < `RV_NREGS; n++) begin
            next_cycle("fill");
            exec_addr = n[4:0];
            exec_data = fill_word(n[4:0]);
        end
        next_cycle("fill");
        idle_inputs();
        repeat (3) next_cycle("fill drain");

        repeat (300) begin
            next_cycle("retire");
            random_inputs(1'b0, 1'b0);
        end
        next_cycle("retire");
        idle_inputs();
        exec_data = 32'hFFFF_FFFF; // A real result aimed at x0
        a_raddr   = '0;
        next_cycle("x0 result");
        idle_inputs();
        repeat (3) next_cycle("retire drain");
        repeat (40) begin
            next_cycle("readback");
            compare("readback array a", array_value(m_a_addr), a_rdata);
            compare("readback array b", array_value(m_b_addr), b_rdata);
            r       = rand32();
            a_raddr = r[31:27];
            r       = rand32();
            b_raddr = r[31:27];
        end

        repeat (400) begin
            next_cycle("forward");
            random_inputs(1'b1, 1'b0);
        end

        next_cycle("forward");
        idle_inputs();
        repeat (3) next_cycle("valid drain");
        saved        = m_regs[12];
        pending_addr = 5'd9;
        b_raddr      = 5'd9;
        a_raddr      = 5'd12;
        exec_en      = 1'b0; // Load result still unknown in execute
        exec_addr    = 5'd12;
        exec_data    = 32'h0BAD_F00D;
        next_cycle("valid flags");
        compare("pending match b_rvalid", 32'd0, 32'(b_rvalid));
        compare("unknown exec a_rvalid", 32'd0, 32'(a_rvalid));
        idle_inputs();
        repeat (4) next_cycle("valid drain");
        compare("unknown result dropped", saved, a_rdata);

        repeat (600) begin
            next_cycle("control");
            random_inputs(1'b1, 1'b1);
        end
        next_cycle("control");
        idle_inputs();
        repeat (4) next_cycle("control drain");

        write_debug("halt set", `RV_DBG_CTRL, 32'd1, OKAY);
        compare("halted set", 32'd1, 32'(halted));
        for (int n = 0; n < `RV_NREGS; n++) begin
            read_debug($sformatf("debug read x%0d", n), `RV_DBG_REG_BASE + 32'(4 * n),
                       array_value(n[4:0]), OKAY, 1'b1);
        end
        read_debug("debug read ctrl", `RV_DBG_CTRL, 32'd1, OKAY, 1'b1);
        read_debug("unmapped read low", 32'h0000_0004, '0, SLVERR, 1'b0);
        read_debug("unmapped read high", `RV_DBG_REG_BASE + 32'(4 * `RV_NREGS), '0, SLVERR, 1'b0);
        write_debug("unmapped write", `RV_DBG_REG_BASE + 32'd4, 32'd1, SLVERR);
        write_debug("halt clear", `RV_DBG_CTRL, 32'd0, OKAY);
        compare("halted clear", 32'd0, 32'(halted));

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== rv32i_operand_unit.f ====
+incdir+.
+incdir+test
logic/rv32i_pkg.sv
logic/rv32i_reg.sv
logic/rv32i_result_pipe.sv
logic/rv32i_dbg_axil.sv
logic/rv32i_operand_unit.sv
test/rv32i_operand_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f rv32i_operand_unit.f \
    --top-module rv32i_operand_unit_tb -o rv32i_operand_unit_sim

./obj_dir/rv32i_operand_unit_sim 2>&1 | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
